// ==== all.f ====
+incdir+.
apb_mem_pkg.sv
apb_mem_decode.sv
apb_mem_array.sv
apb_mem_resp.sv
apb_mem_top.sv
apb_mem_assert.sv
tb_apb_mem.sv

// ==== apb_mem_array.sv ====
// Single-port word memory with byte-lane write strobes
// Read data is registered and held until the next selected read
// Contents are undefined after power-up and are not touched by reset

`default_nettype none

`include "apb_mem_defines.svh"

module apb_mem_array (
  input  logic                  pclk,
  input  apb_mem_pkg::mem_req_t req,
  output apb_mem_pkg::data_t    rdata
);

  import apb_mem_pkg::*;

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------

  data_t mem [`APB_MEM_DEPTH];

  // Read port register
  data_t rdata_q;

  // Decoded strobes
  logic  wr_en;
  logic  rd_en;

  assign wr_en = req.cs && req.we;
  assign rd_en = req.cs && !req.we;

  // --------------------------------------------------------------------------
  // Write port
  // --------------------------------------------------------------------------

  // Only lanes with a set strobe are updated
  // The other lanes keep their earlier contents
  always_ff @(posedge pclk) begin
    if (wr_en) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (req.strb[i]) begin
          mem[req.addr][i*8 +: 8] <= req.wdata[i*8 +: 8];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Read port
  // --------------------------------------------------------------------------

  // Word is captured on the edge that ends the selecting cycle
  // Holds its value while the array is not read
  always_ff @(posedge pclk) begin
    if (rd_en) begin
      rdata_q <= mem[req.addr];
    end
  end

  assign rdata = rdata_q;

endmodule

`default_nettype wire

// ==== apb_mem_assert.sv ====
// Concurrent checks bound into the decode and response blocks
// RESP_SIDE picks the group of properties that is active in an instance
// All properties are off while presetn is high

`default_nettype none

`include "apb_mem_defines.svh"

module apb_mem_assert #(
  parameter bit RESP_SIDE = 1'b0
) (
  input logic                    pclk,
  input logic                    presetn,
  input logic                    psel,
  input logic                    penable,
  input logic                    pwrite,
  input apb_mem_pkg::paddr_t     paddr,
  input apb_mem_pkg::apb_phase_e phase,
  input apb_mem_pkg::mem_req_t   req,
  input apb_mem_pkg::rd_stat_t   stat,
  input apb_mem_pkg::data_t      prdata,
  input logic                    pslverr
);

  timeunit 1ns;
  timeprecision 1ps;

  import apb_mem_pkg::*;

  // End of the mapped window in bytes
  localparam paddr_t MEM_BYTES = paddr_t'(`APB_MEM_DEPTH * STRB_W);

  logic in_range;

  assign in_range = (paddr < MEM_BYTES);

  // --------------------------------------------------------------------------
  // Decode side
  // --------------------------------------------------------------------------

  if (!RESP_SIDE) begin : g_decode
    // Access cycle only straight after a setup cycle
    a_bus_order: assert property (@(posedge pclk) disable iff (presetn)
      (psel && penable) |-> $past(psel && !penable))
      else $error("penable high without a preceding setup cycle");

    // Tracked phase is SETUP whenever the bus is in an access cycle
    a_phase_order: assert property (@(posedge pclk) disable iff (presetn)
      (psel && penable) |-> (phase == PH_SETUP))
      else $error("decode phase not SETUP during a bus access cycle");

    // Tracked phase drops back to IDLE after a cycle without psel
    a_phase_idle: assert property (@(posedge pclk) disable iff (presetn)
      !psel |=> (phase == PH_IDLE))
      else $error("decode phase not IDLE after an idle bus cycle");

    // Reads select in setup, writes in access, never out of range
    a_cs_map: assert property (@(posedge pclk) disable iff (presetn)
      req.cs == (psel && in_range && (!pwrite || penable)))
      else $error("memory select does not follow the bus");

    a_we_addr_map: assert property (@(posedge pclk) disable iff (presetn)
      req.cs |-> (req.we == pwrite && req.addr == word_addr_t'(paddr >> BYTE_LSB)))
      else $error("memory write enable or word address wrong");
  end else begin : g_resp
    // Error only in the access cycle of an out-of-range transfer
    a_err_map: assert property (@(posedge pclk) disable iff (presetn)
      pslverr == (stat.access && stat.err))
      else $error("pslverr does not match the range check");

    a_prdata_quiet: assert property (@(posedge pclk) disable iff (presetn)
      !(stat.access && stat.rd) |-> (prdata == '0))
      else $error("prdata not zero outside a read access");
  end

endmodule

bind apb_mem_decode apb_mem_assert #(.RESP_SIDE(1'b0)) u_decode_chk (
  .pclk    (pclk),
  .presetn (presetn),
  .psel    (psel),
  .penable (penable),
  .pwrite  (pwrite),
  .paddr   (paddr),
  .phase   (phase_q),
  .req     (mem_req),
  .stat    (rd_stat),
  .prdata  ('0),
  .pslverr (1'b0)
);

bind apb_mem_resp apb_mem_assert #(.RESP_SIDE(1'b1)) u_resp_chk (
  .pclk    (pclk),
  .presetn (presetn),
  .psel    (1'b0),
  .penable (1'b0),
  .pwrite  (1'b0),
  .paddr   ('0),
  .phase   (apb_mem_pkg::PH_IDLE),
  .req     ('0),
  .stat    (stat),
  .prdata  (prdata),
  .pslverr (pslverr)
);

`default_nettype wire

// ==== apb_mem_decode.sv ====
// APB front end of the memory slave
// Assumes a zero-wait-state slave so every setup cycle is followed by one access
// Out-of-range transfers are flagged and never select the memory

`default_nettype none

`include "apb_mem_defines.svh"

module apb_mem_decode (
  input  logic                  pclk,
  input  logic                  presetn,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  apb_mem_pkg::paddr_t   paddr,
  input  apb_mem_pkg::data_t    pwdata,
  input  apb_mem_pkg::strb_t    pstrb,
  output apb_mem_pkg::mem_req_t mem_req,
  output apb_mem_pkg::rd_stat_t rd_stat
);

  import apb_mem_pkg::*;

  // Size of the mapped window in bytes
  localparam paddr_t MEM_BYTES = paddr_t'(`APB_MEM_DEPTH) << BYTE_LSB;

  apb_phase_e phase_q;
  apb_phase_e phase_d;
  logic       in_range;
  logic       access_ok;

  // --------------------------------------------------------------------------
  // Phase tracking
  // --------------------------------------------------------------------------

  // phase_q holds the phase of the previous cycle
  // phase_d classifies the cycle now on the bus
  always_comb begin
    phase_d = PH_IDLE;
    if (psel && !penable) begin
      phase_d = PH_SETUP;
    end else if (psel && penable && (phase_q == PH_SETUP)) begin
      // Access is only legal straight after a setup cycle
      phase_d = PH_ACCESS;
    end
  end

  // IDLE -> SETUP -> ACCESS -> IDLE, or ACCESS -> SETUP on back-to-back
  always_ff @(posedge pclk) begin
    if (presetn) begin
      phase_q <= PH_IDLE;
    end else begin
      phase_q <= phase_d;
    end
  end

  assign access_ok = (phase_d == PH_ACCESS);

  // --------------------------------------------------------------------------
  // Address check
  // --------------------------------------------------------------------------

  // Anything at or past the end of the array is an error
  assign in_range = (paddr < MEM_BYTES);

  // --------------------------------------------------------------------------
  // Memory request
  // --------------------------------------------------------------------------

  always_comb begin
    mem_req.we    = pwrite;
    mem_req.addr  = paddr[BYTE_LSB +: WORD_ADDR_W];
    mem_req.wdata = pwdata;
    mem_req.strb  = pstrb;
    // Reads select in setup so data is ready for the access cycle
    // Writes select only in a qualified access cycle
    if (pwrite) begin
      mem_req.cs = psel && in_range && access_ok;
    end else begin
      mem_req.cs = psel && in_range;
    end
  end

  // --------------------------------------------------------------------------
  // Status for the response side
  // --------------------------------------------------------------------------

  always_comb begin
    rd_stat.access = psel && penable;
    rd_stat.rd     = !pwrite;
    rd_stat.err    = !in_range;
  end

endmodule

`default_nettype wire

// ==== apb_mem_defines.svh ====
// Build-time sizes of the APB memory slave
// Data width must be a multiple of 8 and the depth a power of two
// Bus address width is fixed by the APB system at 32 bits

`ifndef APB_MEM_DEFINES_SVH
`define APB_MEM_DEFINES_SVH

// ---------------------------------------------------------------------------
// Data path
// ---------------------------------------------------------------------------

// Bits per memory word and per pwdata/prdata beat
`define APB_MEM_DATA_W 32

// ---------------------------------------------------------------------------
// Address map
// ---------------------------------------------------------------------------

// Words in the array
`define APB_MEM_DEPTH 1024

// Byte address width of paddr
`define APB_MEM_PADDR_W 32

`endif

// ==== apb_mem_pkg.sv ====
// Shared types of the APB memory slave
// All widths derive from the macros in the defines header

`default_nettype none

`include "apb_mem_defines.svh"

package apb_mem_pkg;

  // Byte lanes per word and the paddr bits they consume
  localparam int STRB_W      = `APB_MEM_DATA_W / 8;
  localparam int BYTE_LSB    = $clog2(STRB_W);
  localparam int WORD_ADDR_W = $clog2(`APB_MEM_DEPTH);

  typedef logic [`APB_MEM_DATA_W-1:0]  data_t;
  typedef logic [STRB_W-1:0]           strb_t;
  typedef logic [`APB_MEM_PADDR_W-1:0] paddr_t;
  typedef logic [WORD_ADDR_W-1:0]      word_addr_t;

  // Phase of the current bus cycle as seen by the slave
  typedef enum logic [1:0] {
    PH_IDLE   = 2'd0,
    PH_SETUP  = 2'd1,
    PH_ACCESS = 2'd2
  } apb_phase_e;

  // Strobes into the memory array
  typedef struct packed {
    logic       cs;
    logic       we;
    word_addr_t addr;
    data_t      wdata;
    strb_t      strb;
  } mem_req_t;

  // Status that the response side needs
  typedef struct packed {
    logic access;
    logic rd;
    logic err;
  } rd_stat_t;

endpackage

`default_nettype wire

// ==== apb_mem_resp.sv ====
// Response side of the APB memory slave
// prdata carries the memory word only in an in-range read access cycle
// Both outputs stay zero while reset is applied

`default_nettype none

module apb_mem_resp (
  input  logic                  pclk,
  input  logic                  presetn,
  input  apb_mem_pkg::rd_stat_t stat,
  input  apb_mem_pkg::data_t    rdata,
  output apb_mem_pkg::data_t    prdata,
  output logic                  pslverr
);

  import apb_mem_pkg::*;

  // Low from the first reset edge until one cycle after release
  logic live_q;

  // Response qualifiers
  logic rd_hit;
  logic err_hit;

  // --------------------------------------------------------------------------
  // Reset tracking
  // --------------------------------------------------------------------------

  always_ff @(posedge pclk) begin
    if (presetn) begin
      live_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Output forming
  // --------------------------------------------------------------------------

  // Good read in its access cycle
  assign rd_hit  = live_q && stat.access && stat.rd && !stat.err;

  // Error flagged for reads and writes alike
  assign err_hit = live_q && stat.access && stat.err;

  // Zero outside a valid read keeps stale words off the bus
  always_comb begin
    if (rd_hit) begin
      prdata = rdata;
    end else begin
      prdata = '0;
    end
  end

  assign pslverr = err_hit;

endmodule

`default_nettype wire

// ==== apb_mem_top.sv ====
// APB4 slave wrapping a word memory
// Zero wait states; pready is high whenever reset is not applied
// No protection signals and no memory initialization

`default_nettype none

module apb_mem_top (
  input  logic                pclk,
  input  logic                presetn,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  apb_mem_pkg::paddr_t paddr,
  input  apb_mem_pkg::data_t  pwdata,
  input  apb_mem_pkg::strb_t  pstrb,
  output apb_mem_pkg::data_t  prdata,
  output logic                pready,
  output logic                pslverr
);

  import apb_mem_pkg::*;

  // --------------------------------------------------------------------------
  // Internal links
  // --------------------------------------------------------------------------

  mem_req_t mem_req;
  rd_stat_t rd_stat;
  data_t    mem_rdata;

  // Every transfer ends in its first access cycle
  assign pready = !presetn;

  // Bus to memory strobes and status
  apb_mem_decode u_decode (
    .pclk    (pclk),
    .presetn (presetn),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .mem_req (mem_req),
    .rd_stat (rd_stat)
  );

  // Storage
  apb_mem_array u_array (
    .pclk  (pclk),
    .req   (mem_req),
    .rdata (mem_rdata)
  );

  // Read data and error back to the bus
  apb_mem_resp u_resp (
    .pclk    (pclk),
    .presetn (presetn),
    .stat    (rd_stat),
    .rdata   (mem_rdata),
    .prdata  (prdata),
    .pslverr (pslverr)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Compile the APB memory slave testbench with Verilator and run it.
# The run counts as passed only when the testbench prints its pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_apb_mem -f all.f -o tb_apb_mem &&
./obj_dir/tb_apb_mem | tee /dev/stderr | grep "Regression passed" > /dev/null &&
echo "run.sh: simulation finished without errors" ||
{ echo "run.sh: simulation did not pass"; exit 1; }

// ==== tb_apb_mem.sv ====
// Testbench for the APB memory slave
// Directed table first and random transfers after it
// Table values assume the default 32-bit data width and 1024-word depth
// Lanes never written read as undefined and are left out of the compare

`default_nettype none

`include "apb_mem_defines.svh"

module tb_apb_mem;

  timeunit 1ns;
  timeprecision 1ps;

  import apb_mem_pkg::*;

  localparam int     CLK_PERIOD    = 40;
  localparam int     RESET_CYCLES  = 8;
  localparam int     READY_TIMEOUT = 16;
  localparam int     NUM_RANDOM    = 200;
  localparam logic   WR            = 1'b1;
  localparam logic   RD            = 1'b0;
  localparam paddr_t MEM_BYTES     = paddr_t'(`APB_MEM_DEPTH * STRB_W);

  // One row of the directed table
  typedef struct packed {
    logic   is_write;
    paddr_t addr;
    data_t  wdata;
    strb_t  strb;
    data_t  exp_rdata;
    logic   exp_err;
  } vec_t;

  logic   pclk;
  logic   presetn;
  logic   psel;
  logic   penable;
  logic   pwrite;
  paddr_t paddr;
  data_t  pwdata;
  strb_t  pstrb;
  data_t  prdata;
  logic   pready;
  logic   pslverr;

  vec_t   vec_q[$];
  integer seed;

  // Reference memory with word contents and the lanes known to be written
  data_t  model_mem[int];
  strb_t  model_valid[int];

  apb_mem_top i_dut (
    .pclk    (pclk),
    .presetn (presetn),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    pclk = 1'b0;
    forever #(CLK_PERIOD / 2) pclk = ~pclk;
  end

  // --------------------------------------------------------------------------
  // Failure handling
  // --------------------------------------------------------------------------

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_mismatch(input string what);
    stop_run($sformatf("MISMATCH at %0t ns: %s", $time, what));
  endtask

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------

  function automatic logic addr_in_range(input paddr_t addr);
    return addr < MEM_BYTES;
  endfunction

  // Merge the strobed lanes; out-of-range writes never land
  function automatic void model_write(input paddr_t addr, input data_t data,
                                      input strb_t strb);
    data_t word;
    strb_t valid;
    int    idx;
    if (!addr_in_range(addr)) return;
    idx   = int'(addr >> BYTE_LSB);
    word  = model_mem.exists(idx) ? model_mem[idx] : '0;
    valid = model_valid.exists(idx) ? model_valid[idx] : '0;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        word[i*8 +: 8] = data[i*8 +: 8];
        valid[i]       = 1'b1;
      end
    end
    model_mem[idx]   = word;
    model_valid[idx] = valid;
  endfunction

  // Expected prdata and the lanes worth comparing
  function automatic void model_expect(input paddr_t addr, output data_t exp_rdata,
                                       output data_t mask);
    int idx;
    exp_rdata = '0;
    mask      = '1;
    if (addr_in_range(addr)) begin
      idx  = int'(addr >> BYTE_LSB);
      mask = '0;
      if (model_mem.exists(idx)) begin
        exp_rdata = model_mem[idx];
        for (int i = 0; i < STRB_W; i++) begin
          if (model_valid[idx][i]) mask[i*8 +: 8] = 8'hFF;
        end
      end
    end
  endfunction

  // --------------------------------------------------------------------------
  // Bus tasks
  // --------------------------------------------------------------------------

  // Sample a quarter period after the falling edge, well clear of the rising edge
  task automatic wait_ready;
    int cycles;
    cycles = 0;
    #(CLK_PERIOD / 4);
    while (!pready && cycles < READY_TIMEOUT) begin
      @(negedge pclk);
      #(CLK_PERIOD / 4);
      cycles++;
    end
    assert (pready === 1'b1) else stop_run("Timeout: pready never rose in the access cycle");
  endtask

  task automatic apb_write(input paddr_t addr, input data_t data, input strb_t strb,
                           output data_t rdata, output logic err);
    @(negedge pclk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    pstrb   = strb;
    @(negedge pclk);
    penable = 1'b1;
    wait_ready();
    rdata = prdata;
    err   = pslverr;
  endtask

  task automatic apb_read(input paddr_t addr, output data_t rdata, output logic err);
    @(negedge pclk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    pstrb   = '0;
    @(negedge pclk);
    penable = 1'b1;
    wait_ready();
    rdata = prdata;
    err   = pslverr;
  endtask

  // Drop psel for one cycle; the bus must be quiet
  task automatic bus_idle;
    @(negedge pclk);
    psel    = 1'b0;
    penable = 1'b0;
    #(CLK_PERIOD / 4);
    assert (pready === 1'b1) else report_mismatch("pready low on an idle bus");
    assert (pslverr === 1'b0) else report_mismatch("pslverr high on an idle bus");
    assert (prdata === '0)
      else report_mismatch($sformatf("prdata %h on an idle bus", prdata));
  endtask

  task automatic check_transfer(input paddr_t addr, input data_t rdata, input logic err,
                                input data_t exp_rdata, input data_t mask,
                                input logic exp_err);
    assert (err === exp_err)
      else report_mismatch($sformatf("pslverr %b, expected %b, paddr %h",
                                     err, exp_err, addr));
    assert ((rdata & mask) === (exp_rdata & mask))
      else report_mismatch($sformatf("prdata %h, expected %h, paddr %h",
                                     rdata, exp_rdata, addr));
  endtask

  // --------------------------------------------------------------------------
  // Directed table
  // --------------------------------------------------------------------------

  function automatic void add_entry(input logic is_write, input paddr_t addr,
                                    input data_t wdata, input strb_t strb,
                                    input data_t exp_rdata, input logic exp_err);
    vec_t v;
    v.is_write  = is_write;
    v.addr      = addr;
    v.wdata     = wdata;
    v.strb      = strb;
    v.exp_rdata = exp_rdata;
    v.exp_err   = exp_err;
    vec_q.push_back(v);
  endfunction

  function automatic void load_table;
    paddr_t last_addr;
    last_addr = MEM_BYTES - paddr_t'(STRB_W);
    // Full words with the first and last included
    add_entry(WR, 32'h0000_0000, 32'h1122_3344, 4'hF, '0, 1'b0);
    add_entry(WR, 32'h0000_0004, 32'hA5A5_5A5A, 4'hF, '0, 1'b0);
    add_entry(WR, 32'h0000_0008, 32'hCAFE_F00D, 4'hF, '0, 1'b0);
    add_entry(WR, last_addr, 32'hDEAD_BEEF, 4'hF, '0, 1'b0);
    add_entry(RD, 32'h0000_0000, '0, '0, 32'h1122_3344, 1'b0);
    add_entry(RD, 32'h0000_0004, '0, '0, 32'hA5A5_5A5A, 1'b0);
    add_entry(RD, 32'h0000_0008, '0, '0, 32'hCAFE_F00D, 1'b0);
    add_entry(RD, last_addr, '0, '0, 32'hDEAD_BEEF, 1'b0);
    // Lanes 0 and 2, then lane 1 of the last word
    add_entry(WR, 32'h0000_0000, 32'hAABB_CCDD, 4'h5, '0, 1'b0);
    add_entry(RD, 32'h0000_0000, '0, '0, 32'h11BB_33DD, 1'b0);
    add_entry(WR, last_addr, 32'h0000_7700, 4'h2, '0, 1'b0);
    add_entry(RD, last_addr, '0, '0, 32'hDEAD_77EF, 1'b0);
    // Out-of-range writes leave the aliased words untouched
    add_entry(WR, MEM_BYTES + 32'd4, 32'hFFFF_FFFF, 4'hF, '0, 1'b1);
    add_entry(RD, MEM_BYTES + 32'd4, '0, '0, '0, 1'b1);
    add_entry(RD, 32'h0000_0004, '0, '0, 32'hA5A5_5A5A, 1'b0);
    add_entry(WR, MEM_BYTES, 32'h0000_0000, 4'hF, '0, 1'b1);
    add_entry(RD, 32'h0000_0000, '0, '0, 32'h11BB_33DD, 1'b0);
    add_entry(RD, 32'hFFFF_FFFC, '0, '0, '0, 1'b1);
  endfunction

  task automatic run_entry(input vec_t v);
    data_t rdata;
    logic  err;
    if (v.is_write) begin
      apb_write(v.addr, v.wdata, v.strb, rdata, err);
      model_write(v.addr, v.wdata, v.strb);
    end else begin
      apb_read(v.addr, rdata, err);
    end
    check_transfer(v.addr, rdata, err, v.exp_rdata, '1, v.exp_err);
    bus_idle();
  endtask

  // --------------------------------------------------------------------------
  // Random transfers
  // --------------------------------------------------------------------------

  // Words drawn from the bottom and top 16 of the array with about 1 in 8 out of range
  task automatic run_random;
    logic [31:0] r;
    paddr_t      addr;
    data_t       wdata;
    strb_t       strb;
    data_t       rdata;
    data_t       exp_rdata;
    data_t       mask;
    logic        err;
    logic        exp_err;
    int          idx;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r     = $random(seed);
      wdata = $random(seed);
      strb  = strb_t'(r[15:12]);
      idx   = r[4] ? (`APB_MEM_DEPTH - 16 + int'(r[3:0])) : int'(r[3:0]);
      if (r[7:5] == 3'd0) begin
        addr = paddr_t'(MEM_BYTES * (r[9:8] + 1) + idx * STRB_W);
      end else begin
        addr = paddr_t'(idx * STRB_W);
      end
      exp_err = !addr_in_range(addr);
      if (r[10]) begin
        apb_write(addr, wdata, strb, rdata, err);
        model_write(addr, wdata, strb);
        exp_rdata = '0;
        mask      = '1;
      end else begin
        apb_read(addr, rdata, err);
        model_expect(addr, exp_rdata, mask);
      end
      check_transfer(addr, rdata, err, exp_rdata, mask, exp_err);
      // Otherwise psel stays high into the next setup
      if (r[16] || n == NUM_RANDOM - 1) bus_idle();
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    seed    = 58707;
    presetn = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    pstrb   = '0;
    load_table();

    // Reads held on the bus during the middle reset cycles
    // Odd cycles go out of range, even cycles hit word 0
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge pclk);
      psel    = (i > 0) && (i < RESET_CYCLES - 1);
      penable = psel;
      paddr   = (i % 2 == 1) ? MEM_BYTES : '0;
      #(CLK_PERIOD / 4);
      assert (pready === 1'b0 && pslverr === 1'b0 && prdata === '0)
        else report_mismatch($sformatf("in reset pready %b pslverr %b prdata %h",
                                       pready, pslverr, prdata));
    end
    @(negedge pclk);
    presetn = 1'b0;
    paddr   = '0;
    bus_idle();
    bus_idle();

    foreach (vec_q[i]) begin
      run_entry(vec_q[i]);
    end

    run_random();

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire
